// ==== src/eth_mac_pkg.sv ====
package eth_mac_pkg;

    // One byte of the ready/valid stream
    typedef struct packed {
        logic [7:0] data;
        logic       last;
        // Bad frame marker on both directions
        logic       user;
    } axis_byte_t;

    // Frame FIFO depths in beats, powers of two
    localparam int TX_FIFO_DEPTH = 2048;
    localparam int RX_FIFO_DEPTH = 256;

    // Frame length before the FCS, short payloads get zero padding
    localparam int MIN_PAYLOAD_LEN = 60;
    localparam int FCS_LEN         = 4;

    // Shortest inter-frame gap in cycles, whatever ifg_delay says
    localparam int MIN_IFG_LEN = 12;

    // GMII framing
    localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
    localparam logic [7:0] SFD_BYTE      = 8'hD5;
    localparam int         PREAMBLE_LEN  = 7;

    // CRC-32 polynomial 0x04C11DB7 in bit-reversed form
    localparam logic [31:0] CRC_POLY_REFL = 32'hEDB88320;

    // Left in the CRC register once a good frame's FCS has gone through
    localparam logic [31:0] CRC_RESIDUE = 32'hDEBB20E3;

    // One byte step of the reflected CRC-32, LSB of the byte first.
    // Start from all ones and send the inverted state LSB byte first.
    function automatic logic [31:0] crc32_byte(
        input logic [31:0] crc,
        input logic [7:0]  data
    );
        logic [31:0] c;
        c = crc ^ {24'd0, data};
        for (int i = 0; i < 8; i++) begin
            if (c[0]) begin
                c = (c >> 1) ^ CRC_POLY_REFL;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

endpackage

// ==== src/frame_fifo.sv ====
`timescale 1ns/1ns

// Store-and-forward FIFO, DEPTH must be a power of two
module frame_fifo import eth_mac_pkg::*; #(
    parameter int DEPTH          = 256,
    parameter bit DROP_WHEN_FULL = 1'b0
) (
    input  logic       logic_clk,
    input  logic       logic_rst,
    input  axis_byte_t in_beat,
    input  logic       in_valid,
    output logic       in_ready,
    output axis_byte_t out_beat,
    output logic       out_valid,
    input  logic       out_ready,
    output logic       good_frame,
    output logic       bad_frame,
    output logic       overflow
);

    localparam int ADDR_W = $clog2(DEPTH);

    axis_byte_t mem [DEPTH];

    logic [ADDR_W:0] wr_ptr;
    logic [ADDR_W:0] wr_ptr_commit;
    logic [ADDR_W:0] rd_ptr;
    logic [ADDR_W:0] spec_count;
    logic            full;
    logic            drop_frame;
    logic            in_accept;
    logic            drop_beat;
    logic            wr_en;
    logic            rd_en;

    // Full against the speculative pointer, so an open frame counts
    assign full       = (wr_ptr == {~rd_ptr[ADDR_W], rd_ptr[ADDR_W-1:0]});
    assign in_ready   = DROP_WHEN_FULL || !full;
    assign in_accept  = in_valid && in_ready;
    assign drop_beat  = drop_frame || full;
    assign wr_en      = in_accept && !drop_beat;
    assign spec_count = wr_ptr - wr_ptr_commit;

    // Reads stop at the last committed frame
    assign rd_en = (rd_ptr != wr_ptr_commit) && (!out_valid || out_ready);

    always_ff @(posedge logic_clk) begin
        if (wr_en) begin
            mem[wr_ptr[ADDR_W-1:0]] <= in_beat;
        end
        if (rd_en) begin
            out_beat <= mem[rd_ptr[ADDR_W-1:0]];
        end
    end

    // Write side with commit and rewind
    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            wr_ptr        <= '0;
            wr_ptr_commit <= '0;
            drop_frame    <= 1'b0;
            good_frame    <= 1'b0;
            bad_frame     <= 1'b0;
            overflow      <= 1'b0;
        end else begin
            good_frame <= 1'b0;
            bad_frame  <= 1'b0;
            overflow   <= 1'b0;
            if (in_accept) begin
                if (drop_beat) begin
                    // No room, throw away what was written and skip the rest
                    wr_ptr     <= wr_ptr_commit;
                    drop_frame <= !in_beat.last;
                    overflow   <= in_beat.last;
                end else if (in_beat.last && in_beat.user) begin
                    wr_ptr    <= wr_ptr_commit;
                    bad_frame <= 1'b1;
                end else if (in_beat.last) begin
                    wr_ptr        <= wr_ptr + 1'b1;
                    wr_ptr_commit <= wr_ptr + 1'b1;
                    good_frame    <= 1'b1;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
        end
    end

    // Read side, one output register
    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            rd_ptr    <= '0;
            out_valid <= 1'b0;
        end else if (rd_en) begin
            rd_ptr    <= rd_ptr + 1'b1;
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    // Open frame never larger than the buffer
    a_commit_behind_write: assert property (
        @(posedge logic_clk) disable iff (logic_rst)
        spec_count <= DEPTH
    );

    a_out_stable: assert property (
        @(posedge logic_clk) disable iff (logic_rst)
        out_valid && !out_ready |=> out_valid && $stable(out_beat)
    );

endmodule

// ==== src/gmii_tx.sv ====
`timescale 1ns/1ns

module gmii_tx import eth_mac_pkg::*; (
    input  logic       logic_clk,
    input  logic       logic_rst,
    input  axis_byte_t tx_beat,
    input  logic       tx_valid,
    output logic       tx_ready,
    input  logic [7:0] ifg_delay,
    output logic [7:0] gmii_txd,
    output logic       gmii_tx_en,
    output logic       gmii_tx_er
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_PREAMBLE,
        ST_PAYLOAD,
        ST_PAD,
        ST_FCS,
        ST_GAP
    } tx_state_t;

    tx_state_t   state;
    axis_byte_t  beat_reg;
    logic [31:0] crc_reg;
    logic [7:0]  cnt;
    logic [15:0] byte_cnt;
    logic [7:0]  gap_len;
    logic        tx_accept;

    assign gap_len = (ifg_delay < 8'(MIN_IFG_LEN)) ? 8'(MIN_IFG_LEN) : ifg_delay;

    // First beat taken in idle, the rest one per payload cycle
    assign tx_ready  = (state == ST_IDLE) ||
                       ((state == ST_PAYLOAD) && !beat_reg.last);
    assign tx_accept = tx_valid && tx_ready;

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            state      <= ST_IDLE;
            cnt        <= '0;
            byte_cnt   <= '0;
            gmii_txd   <= '0;
            gmii_tx_en <= 1'b0;
            gmii_tx_er <= 1'b0;
        end else begin
            // Frames are never aborted
            gmii_tx_er <= 1'b0;
            case (state)
                ST_IDLE: begin
                    gmii_txd   <= '0;
                    gmii_tx_en <= 1'b0;
                    if (tx_valid) begin
                        gmii_txd   <= PREAMBLE_BYTE;
                        gmii_tx_en <= 1'b1;
                        cnt        <= 8'd1;
                        byte_cnt   <= '0;
                        state      <= ST_PREAMBLE;
                    end
                end
                ST_PREAMBLE: begin
                    cnt <= cnt + 8'd1;
                    if (cnt == 8'(PREAMBLE_LEN)) begin
                        gmii_txd <= SFD_BYTE;
                        state    <= ST_PAYLOAD;
                    end else begin
                        gmii_txd <= PREAMBLE_BYTE;
                    end
                end
                ST_PAYLOAD: begin
                    gmii_txd <= beat_reg.data;
                    byte_cnt <= byte_cnt + 16'd1;
                    if (beat_reg.last) begin
                        cnt <= '0;
                        if (byte_cnt + 16'd1 < 16'(MIN_PAYLOAD_LEN)) begin
                            state <= ST_PAD;
                        end else begin
                            state <= ST_FCS;
                        end
                    end
                end
                ST_PAD: begin
                    gmii_txd <= 8'h00;
                    byte_cnt <= byte_cnt + 16'd1;
                    if (byte_cnt == 16'(MIN_PAYLOAD_LEN - 1)) begin
                        state <= ST_FCS;
                    end
                end
                ST_FCS: begin
                    gmii_txd <= ~crc_reg[7:0];
                    cnt      <= cnt + 8'd1;
                    if (cnt == 8'(FCS_LEN - 1)) begin
                        cnt   <= '0;
                        state <= ST_GAP;
                    end
                end
                ST_GAP: begin
                    gmii_txd   <= '0;
                    gmii_tx_en <= 1'b0;
                    cnt        <= cnt + 8'd1;
                    if (cnt == gap_len - 8'd1) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Held beat and running CRC
    always_ff @(posedge logic_clk) begin
        if (tx_accept) begin
            beat_reg <= tx_beat;
        end
        case (state)
            ST_IDLE:    crc_reg <= '1;
            ST_PAYLOAD: crc_reg <= crc32_byte(crc_reg, beat_reg.data);
            ST_PAD:     crc_reg <= crc32_byte(crc_reg, 8'h00);
            // Next FCS byte into the low lane
            ST_FCS:     crc_reg <= {8'h00, crc_reg[31:8]};
            default:    crc_reg <= crc_reg;
        endcase
    end

    a_min_gap: assert property (
        @(posedge logic_clk) disable iff (logic_rst)
        $fell(gmii_tx_en) |-> !gmii_tx_en [*MIN_IFG_LEN]
    );

endmodule

// ==== src/gmii_rx.sv ====
`timescale 1ns/1ns

module gmii_rx import eth_mac_pkg::*; (
    input  logic       logic_clk,
    input  logic       logic_rst,
    input  logic [7:0] gmii_rxd,
    input  logic       gmii_rx_dv,
    input  logic       gmii_rx_er,
    output axis_byte_t rx_beat,
    output logic       rx_valid,
    output logic       bad_frame,
    output logic       bad_fcs
);

    // Delay line deep enough to hold back the FCS plus one byte
    logic [7:0]       dly_data [FCS_LEN+1];
    logic [FCS_LEN:0] dly_vld;

    logic [31:0] crc;
    logic [6:0]  len_cnt;
    logic        in_frame;
    logic        pre_seen;
    logic        er_seen;
    logic        frame_end;
    logic        short_frame;
    logic        crc_bad;

    // First idle cycle after the frame
    assign frame_end   = in_frame && !gmii_rx_dv;
    assign short_frame = len_cnt < 7'(MIN_PAYLOAD_LEN + FCS_LEN);
    assign crc_bad     = (crc != CRC_RESIDUE);

    // A byte is payload once four more bytes have followed it
    assign rx_valid = dly_vld[FCS_LEN];
    assign rx_beat  = '{
        data: dly_data[FCS_LEN],
        last: frame_end,
        user: frame_end && (er_seen || short_frame || crc_bad)
    };

    assign bad_frame = frame_end && (er_seen || short_frame);
    assign bad_fcs   = frame_end && crc_bad;

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            in_frame <= 1'b0;
            pre_seen <= 1'b0;
            er_seen  <= 1'b0;
            len_cnt  <= '0;
            dly_vld  <= '0;
        end else if (!gmii_rx_dv) begin
            in_frame <= 1'b0;
            pre_seen <= 1'b0;
            dly_vld  <= '0;
        end else if (!in_frame) begin
            // SFD hunt, only straight after a preamble byte
            pre_seen <= (gmii_rxd == PREAMBLE_BYTE);
            if (pre_seen && gmii_rxd == SFD_BYTE) begin
                in_frame <= 1'b1;
                er_seen  <= 1'b0;
                len_cnt  <= '0;
            end
        end else begin
            dly_vld <= {dly_vld[FCS_LEN-1:0], 1'b1};
            er_seen <= er_seen || gmii_rx_er;
            // Saturate, only the 64 byte threshold matters
            if (short_frame) begin
                len_cnt <= len_cnt + 7'd1;
            end
        end
    end

    always_ff @(posedge logic_clk) begin
        dly_data[0] <= gmii_rxd;
        for (int i = 1; i <= FCS_LEN; i++) begin
            dly_data[i] <= dly_data[i-1];
        end
        // CRC runs over payload and FCS, then holds for the check
        if (!in_frame) begin
            crc <= '1;
        end else if (gmii_rx_dv) begin
            crc <= crc32_byte(crc, gmii_rxd);
        end
    end

    // Every beat left the line FCS_LEN+1 cycles earlier inside a frame
    a_valid_after_sfd: assert property (
        @(posedge logic_clk) disable iff (logic_rst)
        rx_valid |-> $past(in_frame, FCS_LEN + 1)
    );

endmodule

// ==== src/eth_mac_gmii_fifo.sv ====
`timescale 1ns/1ns

module eth_mac_gmii_fifo import eth_mac_pkg::*; (
    input  logic       logic_clk,
    input  logic       logic_rst,

    // User transmit stream
    input  axis_byte_t tx_axis_beat,
    input  logic       tx_axis_valid,
    output logic       tx_axis_ready,

    // User receive stream
    output axis_byte_t rx_axis_beat,
    output logic       rx_axis_valid,
    input  logic       rx_axis_ready,

    // GMII
    input  logic [7:0] gmii_rxd,
    input  logic       gmii_rx_dv,
    input  logic       gmii_rx_er,
    output logic [7:0] gmii_txd,
    output logic       gmii_tx_en,
    output logic       gmii_tx_er,

    // Status strobes
    output logic       tx_fifo_overflow,
    output logic       tx_fifo_bad_frame,
    output logic       tx_fifo_good_frame,
    output logic       rx_error_bad_frame,
    output logic       rx_error_bad_fcs,
    output logic       rx_fifo_overflow,
    output logic       rx_fifo_bad_frame,
    output logic       rx_fifo_good_frame,

    input  logic [7:0] ifg_delay
);

    axis_byte_t tx_mac_beat;
    logic       tx_mac_valid;
    logic       tx_mac_ready;
    axis_byte_t rx_mac_beat;
    logic       rx_mac_valid;

    // Whole frames only, so the MAC never runs dry mid-frame
    frame_fifo #(
        .DEPTH          (TX_FIFO_DEPTH),
        .DROP_WHEN_FULL (1'b0)
    ) tx_fifo (
        .logic_clk  (logic_clk),
        .logic_rst  (logic_rst),
        .in_beat    (tx_axis_beat),
        .in_valid   (tx_axis_valid),
        .in_ready   (tx_axis_ready),
        .out_beat   (tx_mac_beat),
        .out_valid  (tx_mac_valid),
        .out_ready  (tx_mac_ready),
        .good_frame (tx_fifo_good_frame),
        .bad_frame  (tx_fifo_bad_frame),
        .overflow   (tx_fifo_overflow)
    );

    gmii_tx i_gmii_tx (
        .logic_clk  (logic_clk),
        .logic_rst  (logic_rst),
        .tx_beat    (tx_mac_beat),
        .tx_valid   (tx_mac_valid),
        .tx_ready   (tx_mac_ready),
        .ifg_delay  (ifg_delay),
        .gmii_txd   (gmii_txd),
        .gmii_tx_en (gmii_tx_en),
        .gmii_tx_er (gmii_tx_er)
    );

    gmii_rx i_gmii_rx (
        .logic_clk  (logic_clk),
        .logic_rst  (logic_rst),
        .gmii_rxd   (gmii_rxd),
        .gmii_rx_dv (gmii_rx_dv),
        .gmii_rx_er (gmii_rx_er),
        .rx_beat    (rx_mac_beat),
        .rx_valid   (rx_mac_valid),
        .bad_frame  (rx_error_bad_frame),
        .bad_fcs    (rx_error_bad_fcs)
    );

    // The line cannot be stalled, overflowing frames are dropped
    frame_fifo #(
        .DEPTH          (RX_FIFO_DEPTH),
        .DROP_WHEN_FULL (1'b1)
    ) rx_fifo (
        .logic_clk  (logic_clk),
        .logic_rst  (logic_rst),
        .in_beat    (rx_mac_beat),
        .in_valid   (rx_mac_valid),
        .in_ready   (),
        .out_beat   (rx_axis_beat),
        .out_valid  (rx_axis_valid),
        .out_ready  (rx_axis_ready),
        .good_frame (rx_fifo_good_frame),
        .bad_frame  (rx_fifo_bad_frame),
        .overflow   (rx_fifo_overflow)
    );

endmodule

// ==== tests/eth_mac_tb.sv ====
`timescale 1ns/1ns

module eth_mac_tb import eth_mac_pkg::*; ();

    localparam int CLK_PERIOD   = 100;
    localparam int QUIET_LEN    = 100;
    localparam int WAIT_LIMIT   = 3000;
    localparam int ERR_BYTE_IDX = 30;

    // Bytes on the wire (preamble, payload or padding, FCS) plus the gap after each frame
    localparam int WIRE_CYCLES = (72 + 12) + (212 + 12) + 2 * (76 + 12) + 3 * (72 + 20)
                               + 5 * (72 + 12);
    // Loading the TX FIFO and draining the held RX frames
    localparam int LOAD_CYCLES = 20 + 200 + 30 + 2 * 64 + 3 * 40 + 5 * 60 + 240 + 20;
    localparam int WATCHDOG_NS = 2 * (WIRE_CYCLES + LOAD_CYCLES + 8 * QUIET_LEN) * CLK_PERIOD;

    typedef enum {RX_BEATS, RX_FRAMES, TX_FRAMES} watch_t;

    logic       logic_clk;
    logic       logic_rst;
    axis_byte_t tx_axis_beat;
    logic       tx_axis_valid;
    logic       tx_axis_ready;
    axis_byte_t rx_axis_beat;
    logic       rx_axis_valid;
    logic       rx_axis_ready;
    logic [7:0] gmii_rxd;
    logic       gmii_rx_dv;
    logic       gmii_rx_er;
    logic [7:0] gmii_txd;
    logic       gmii_tx_en;
    logic       gmii_tx_er;
    logic       tx_fifo_overflow;
    logic       tx_fifo_bad_frame;
    logic       tx_fifo_good_frame;
    logic       rx_error_bad_frame;
    logic       rx_error_bad_fcs;
    logic       rx_fifo_overflow;
    logic       rx_fifo_bad_frame;
    logic       rx_fifo_good_frame;
    logic [7:0] ifg_delay;

    // Loopback fault injection
    logic flip_bit;
    logic raise_er;
    logic line_hit;

    logic [31:0] rng = 32'hd9ec;
    logic [7:0]  payload[$];
    axis_byte_t  exp_q[$];
    axis_byte_t  rx_q[$];
    logic [7:0]  gmii_q[$];
    int          gap_q[$];

    int tx_byte_idx = 0;
    int low_cnt = 0;
    int tx_er_cnt = 0;
    int tx_frames;
    int tx_good_cnt;
    int tx_bad_cnt;
    int rx_bad_frame_cnt;
    int rx_bad_fcs_cnt;
    int rx_good_cnt;
    int rx_bad_cnt;
    int rx_ovf_cnt;
    int checks = 0;
    int errors = 0;

    eth_mac_gmii_fifo i_dut (.*);

    assign line_hit   = gmii_tx_en && (tx_byte_idx == ERR_BYTE_IDX);
    assign gmii_rxd   = gmii_txd ^ {7'd0, flip_bit && line_hit};
    assign gmii_rx_dv = gmii_tx_en;
    assign gmii_rx_er = gmii_tx_er | (raise_er && line_hit);

    initial begin
        logic_clk = 1'b0;
        forever #(CLK_PERIOD / 2) logic_clk = ~logic_clk;
    end

    // Watches both stream sides, the GMII line and the status strobes
    always @(posedge logic_clk) begin
        if (rx_axis_valid && rx_axis_ready) begin
            rx_q.push_back(rx_axis_beat);
        end
        if (gmii_tx_en) begin
            gmii_q.push_back(gmii_txd);
            if (tx_byte_idx == 0) begin
                gap_q.push_back(low_cnt);
            end
            tx_byte_idx <= tx_byte_idx + 1;
            low_cnt     <= 0;
        end else begin
            if (tx_byte_idx != 0) begin
                tx_frames++;
            end
            tx_byte_idx <= 0;
            low_cnt     <= low_cnt + 1;
        end
        if (gmii_tx_er) tx_er_cnt++;
        if (tx_fifo_good_frame) tx_good_cnt++;
        if (tx_fifo_bad_frame) tx_bad_cnt++;
        if (rx_error_bad_frame) rx_bad_frame_cnt++;
        if (rx_error_bad_fcs) rx_bad_fcs_cnt++;
        if (rx_fifo_good_frame) rx_good_cnt++;
        if (rx_fifo_bad_frame) rx_bad_cnt++;
        if (rx_fifo_overflow) rx_ovf_cnt++;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Result: FAILED");
        $finish;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // MSB-first register form, bit reversed at the end to get the wire order
    function automatic logic [31:0] fcs_of_payload();
        logic [31:0] c;
        logic [31:0] r;
        logic        fb;
        c = '1;
        for (int i = 0; i < payload.size(); i++) begin
            for (int b = 0; b < 8; b++) begin
                fb = c[31] ^ payload[i][b];
                c  = {c[30:0], 1'b0};
                if (fb) begin
                    c = c ^ 32'h04C11DB7;
                end
            end
        end
        for (int k = 0; k < 32; k++) begin
            r[k] = c[31 - k];
        end
        return ~r;
    endfunction

    function automatic int progress(input watch_t what);
        case (what)
            RX_BEATS:  return rx_q.size();
            RX_FRAMES: return rx_good_cnt + rx_bad_cnt + rx_ovf_cnt;
            default:   return tx_frames;
        endcase
    endfunction

    task automatic check_beat(input int idx, input axis_byte_t got, input axis_byte_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: rx beat %0d got %h/%b/%b expected %h/%b/%b", $time, idx,
                     got.data, got.last, got.user, exp.data, exp.last, exp.user);
        end
    endtask

    task automatic check_byte(input string what, input logic [7:0] got, input logic [7:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_strobe(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("Fail at %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic wait_until(input watch_t what, input int n);
        int t;
        t = 0;
        while (progress(what) < n && t < WAIT_LIMIT) begin
            @(negedge logic_clk);
            t++;
        end
        if (progress(what) < n) begin
            errors++;
            $display("Timeout at %0t: %s stuck at %0d, waiting for %0d", $time, what.name(),
                     progress(what), n);
        end
    endtask

    task automatic quiet();
        repeat (QUIET_LEN) @(negedge logic_clk);
    endtask

    task automatic clear_monitors();
        rx_q.delete();
        exp_q.delete();
        gmii_q.delete();
        gap_q.delete();
        tx_frames        = 0;
        tx_good_cnt      = 0;
        tx_bad_cnt       = 0;
        rx_bad_frame_cnt = 0;
        rx_bad_fcs_cnt   = 0;
        rx_good_cnt      = 0;
        rx_bad_cnt       = 0;
        rx_ovf_cnt       = 0;
    endtask

    task automatic fill_payload(input int len);
        payload.delete();
        for (int i = 0; i < len; i++) begin
            rng = xorshift32(rng);
            payload.push_back(rng[7:0]);
        end
    endtask

    // Short payloads come back zero padded to the minimum length
    task automatic expect_frame();
        axis_byte_t b;
        int         n;
        n = (payload.size() < MIN_PAYLOAD_LEN) ? MIN_PAYLOAD_LEN : payload.size();
        for (int i = 0; i < n; i++) begin
            b.data = (i < payload.size()) ? payload[i] : 8'h00;
            b.last = (i == n - 1);
            b.user = 1'b0;
            exp_q.push_back(b);
        end
    endtask

    task automatic send_frame(input logic bad);
        axis_byte_t b;
        for (int i = 0; i < payload.size(); i++) begin
            @(negedge logic_clk);
            b.data = payload[i];
            b.last = (i == payload.size() - 1);
            b.user = bad && b.last;
            tx_axis_beat  = b;
            tx_axis_valid = 1'b1;
            while (!tx_axis_ready) @(negedge logic_clk);
        end
        @(negedge logic_clk);
        tx_axis_valid = 1'b0;
    endtask

    task automatic compare_rx();
        check_count("rx beat count", rx_q.size(), exp_q.size());
        for (int i = 0; i < exp_q.size() && i < rx_q.size(); i++) begin
            check_beat(i, rx_q[i], exp_q[i]);
        end
    endtask

    task automatic min_frame_loopback();
        clear_monitors();
        fill_payload(20);
        expect_frame();
        send_frame(1'b0);
        wait_until(RX_BEATS, MIN_PAYLOAD_LEN);
        quiet();
        compare_rx();
        check_strobe("tx_fifo_good_frame once", tx_good_cnt == 1, 1'b1);
        check_strobe("rx_fifo_good_frame once", rx_good_cnt == 1, 1'b1);
    endtask

    task automatic long_frame_on_wire();
        logic [31:0] fcs;
        clear_monitors();
        fill_payload(200);
        expect_frame();
        fcs = fcs_of_payload();
        send_frame(1'b0);
        wait_until(TX_FRAMES, 1);
        check_count("GMII frame bytes", gmii_q.size(), PREAMBLE_LEN + 1 + 200 + 4);
        if (gmii_q.size() == PREAMBLE_LEN + 1 + 200 + 4) begin
            for (int i = 0; i < PREAMBLE_LEN; i++) begin
                check_byte($sformatf("preamble byte %0d", i), gmii_q[i], PREAMBLE_BYTE);
            end
            check_byte("SFD", gmii_q[PREAMBLE_LEN], SFD_BYTE);
            for (int i = 0; i < 200; i++) begin
                check_byte($sformatf("payload byte %0d", i), gmii_q[PREAMBLE_LEN + 1 + i],
                           payload[i]);
            end
            for (int k = 0; k < 4; k++) begin
                check_byte($sformatf("FCS byte %0d", k), gmii_q[PREAMBLE_LEN + 201 + k],
                           fcs[8 * k +: 8]);
            end
        end
        wait_until(RX_BEATS, 200);
        compare_rx();
    endtask

    task automatic user_bit_drop();
        clear_monitors();
        fill_payload(30);
        send_frame(1'b1);
        quiet();
        check_strobe("tx_fifo_bad_frame once", tx_bad_cnt == 1, 1'b1);
        check_count("GMII bytes of dropped frame", gmii_q.size(), 0);
        check_count("rx beats of dropped frame", rx_q.size(), 0);
    endtask

    task automatic corrupted_line();
        clear_monitors();
        flip_bit = 1'b1;
        fill_payload(64);
        send_frame(1'b0);
        wait_until(RX_FRAMES, 1);
        quiet();
        flip_bit = 1'b0;
        check_strobe("rx_error_bad_fcs once", rx_bad_fcs_cnt == 1, 1'b1);
        check_strobe("rx_error_bad_frame on flipped bit", rx_bad_frame_cnt != 0, 1'b0);
        check_strobe("rx_fifo_bad_frame once", rx_bad_cnt == 1, 1'b1);
        check_count("rx beats after bad FCS", rx_q.size(), 0);

        clear_monitors();
        raise_er = 1'b1;
        fill_payload(64);
        send_frame(1'b0);
        wait_until(RX_FRAMES, 1);
        quiet();
        raise_er = 1'b0;
        check_strobe("rx_error_bad_frame once", rx_bad_frame_cnt == 1, 1'b1);
        check_strobe("rx_error_bad_fcs on rx_er", rx_bad_fcs_cnt != 0, 1'b0);
        check_strobe("rx_fifo_bad_frame once", rx_bad_cnt == 1, 1'b1);
        check_count("rx beats after rx_er", rx_q.size(), 0);
    endtask

    // First gap recorded belongs to the previous test
    task automatic gap_between_frames();
        ifg_delay = 8'd20;
        clear_monitors();
        for (int f = 0; f < 3; f++) begin
            fill_payload(40);
            expect_frame();
            send_frame(1'b0);
        end
        wait_until(TX_FRAMES, 3);
        wait_until(RX_BEATS, 3 * MIN_PAYLOAD_LEN);
        check_count("gaps recorded", gap_q.size(), 3);
        if (gap_q.size() == 3) begin
            for (int i = 1; i < 3; i++) begin
                check_strobe($sformatf("gap %0d of %0d cycles reaches 20", i, gap_q[i]),
                             gap_q[i] >= 20, 1'b1);
            end
        end
        compare_rx();
        ifg_delay = 8'd12;
    endtask

    task automatic rx_backpressure();
        clear_monitors();
        rx_axis_ready = 1'b0;
        for (int f = 0; f < 5; f++) begin
            fill_payload(60);
            // 256 beats hold four frames, the fifth overflows
            if (f < 4) begin
                expect_frame();
            end
            send_frame(1'b0);
        end
        wait_until(RX_FRAMES, 5);
        check_strobe("rx_fifo_overflow seen", rx_ovf_cnt != 0, 1'b1);
        check_count("frames committed to rx FIFO", rx_good_cnt, 4);
        @(negedge logic_clk);
        rx_axis_ready = 1'b1;
        wait_until(RX_BEATS, 4 * MIN_PAYLOAD_LEN);
        quiet();
        compare_rx();
    endtask

    initial begin
        logic_rst     = 1'b1;
        tx_axis_beat  = '0;
        tx_axis_valid = 1'b0;
        rx_axis_ready = 1'b1;
        ifg_delay     = 8'd12;
        flip_bit      = 1'b0;
        raise_er      = 1'b0;
        clear_monitors();
        repeat (2) @(posedge logic_clk);
        @(negedge logic_clk);
        logic_rst = 1'b0;
        @(negedge logic_clk);

        check_strobe("tx_axis_ready after reset", tx_axis_ready, 1'b1);
        check_strobe("rx_axis_valid after reset", rx_axis_valid, 1'b0);
        check_strobe("gmii_tx_en after reset", gmii_tx_en, 1'b0);
        check_strobe("status strobes after reset",
                     tx_fifo_overflow | tx_fifo_bad_frame | tx_fifo_good_frame |
                     rx_error_bad_frame | rx_error_bad_fcs | rx_fifo_overflow |
                     rx_fifo_bad_frame | rx_fifo_good_frame, 1'b0);

        min_frame_loopback();
        long_frame_on_wire();
        user_bit_drop();
        corrupted_line();
        gap_between_frames();
        rx_backpressure();

        // The MAC never aborts a frame
        check_count("cycles with gmii_tx_er high", tx_er_cnt, 0);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== eth_mac.f ====
src/eth_mac_pkg.sv
src/frame_fifo.sv
src/gmii_tx.sv
src/gmii_rx.sv
src/eth_mac_gmii_fifo.sv
tests/eth_mac_tb.sv

// ==== Bender.yml ====
package:
  name: eth_mac

sources:
  - files:
      - src/eth_mac_pkg.sv
      - src/frame_fifo.sv
      - src/gmii_tx.sv
      - src/gmii_rx.sv
      - src/eth_mac_gmii_fifo.sv
  - target: test
    files:
      - tests/eth_mac_tb.sv
